// ==== design/soc_pkg.sv ====
// SoC memory-side definitions
package soc_pkg;

    // bus widths
    localparam int ADDR_W  = 64;
    localparam int DATA_W  = 64;
    localparam int INST_W  = 32;
    localparam int WMASK_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [INST_W-1:0]  inst_t;
    typedef logic [WMASK_W-1:0] wmask_t;

    // address map, the timer window is 64 KiB aligned
    localparam addr_t CLINT_BASE    = 64'h0000_0000_0200_0000;
    localparam addr_t CLINT_SIZE    = 64'h0000_0000_0001_0000;
    localparam addr_t MTIMECMP_ADDR = 64'h0000_0000_0200_4000;
    localparam addr_t MTIME_ADDR    = 64'h0000_0000_0200_bff8;

    // number of low address bits inside the timer window
    localparam int CLINT_OFS_W = $clog2(CLINT_SIZE);

    // timer reset values
    localparam data_t MTIME_RESET    = '0;
    localparam data_t MTIMECMP_RESET = '1;

    // one access on the shared bus
    typedef struct packed {
        addr_t  addr;
        data_t  wdata;
        wmask_t wmask;
        logic   we;
    } bus_req_t;

    // response returned with the done pulse
    typedef struct packed {
        data_t rdata;
    } bus_rsp_t;

    // arbiter grant state
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_INST,
        ARB_DATA
    } arb_state_t;

    // external ram bridge state
    typedef enum logic [1:0] {
        BR_IDLE,
        BR_READ,
        BR_CAPTURE,
        BR_WRITE
    } bridge_state_t;

endpackage

// ==== design/mem_arbiter.sv ====
// Instruction and data bus arbiter
`timescale 1ns/1ps

module mem_arbiter (
    input  logic               clk,
    input  logic               i_rst_n,
    // instruction fetch side
    input  logic               i_if_req,
    input  soc_pkg::addr_t     i_if_addr,
    output logic               o_if_done,
    output soc_pkg::inst_t     o_if_inst,
    // data access side
    input  logic               i_mem_req,
    input  logic               i_mem_we,
    input  soc_pkg::addr_t     i_mem_addr,
    input  soc_pkg::data_t     i_mem_wdata,
    input  soc_pkg::wmask_t    i_mem_wmask,
    output logic               o_mem_done,
    output soc_pkg::data_t     o_mem_rdata,
    // shared bus
    output logic               o_bus_valid,
    output soc_pkg::bus_req_t  o_bus_req,
    input  logic               i_bus_done,
    input  soc_pkg::bus_rsp_t  i_bus_rsp
);
    import soc_pkg::*;

    arb_state_t state;
    bus_req_t   next_req;
    bus_req_t   bus_req_q;
    logic       bus_valid_q;
    logic       grant;

    assign grant = (state == ARB_IDLE) && (i_mem_req || i_if_req);

    // data side wins when both ask in the same cycle
    always_comb begin
        if (i_mem_req) begin
            next_req.addr  = i_mem_addr;
            next_req.wdata = i_mem_wdata;
            next_req.wmask = i_mem_wmask;
            next_req.we    = i_mem_we;
        end else begin
            // fetch is always a plain read
            next_req.addr  = i_if_addr;
            next_req.wdata = '0;
            next_req.wmask = '0;
            next_req.we    = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state       <= ARB_IDLE;
            bus_valid_q <= 1'b0;
        end else begin
            bus_valid_q <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    if (i_mem_req) begin
                        state       <= ARB_DATA;
                        bus_valid_q <= 1'b1;
                    end else if (i_if_req) begin
                        state       <= ARB_INST;
                        bus_valid_q <= 1'b1;
                    end
                end
                ARB_INST, ARB_DATA: begin
                    if (i_bus_done) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // request payload held for the whole access
    always_ff @(posedge clk) begin
        if (grant) begin
            bus_req_q <= next_req;
        end
    end

    assign o_bus_valid = bus_valid_q;
    assign o_bus_req   = bus_req_q;

    // done goes back to whoever owns the bus
    assign o_mem_done  = (state == ARB_DATA) && i_bus_done;
    assign o_if_done   = (state == ARB_INST) && i_bus_done;
    assign o_mem_rdata = i_bus_rsp.rdata;

    // pick the 32-bit half by address bit 2
    assign o_if_inst = bus_req_q.addr[2] ? i_bus_rsp.rdata[63:32] : i_bus_rsp.rdata[31:0];

endmodule

// ==== design/bus_router.sv ====
// Address decoder and response merge
`timescale 1ns/1ps

module bus_router (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_bus_valid,
    input  soc_pkg::bus_req_t  i_bus_req,
    output logic               o_bus_done,
    output soc_pkg::bus_rsp_t  o_bus_rsp,
    // target selects
    output logic               o_tmr_valid,
    output logic               o_ram_valid,
    // target responses
    input  logic               i_tmr_done,
    input  soc_pkg::bus_rsp_t  i_tmr_rsp,
    input  logic               i_ram_done,
    input  soc_pkg::bus_rsp_t  i_ram_rsp
);
    import soc_pkg::*;

    logic tmr_hit;
    logic tmr_owner;

    // window is aligned, so only the upper bits need to match
    assign tmr_hit = (i_bus_req.addr[ADDR_W-1:CLINT_OFS_W] == CLINT_BASE[ADDR_W-1:CLINT_OFS_W]);

    assign o_tmr_valid = i_bus_valid && tmr_hit;
    assign o_ram_valid = i_bus_valid && !tmr_hit;

    // remember the target of the outstanding access
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            tmr_owner <= 1'b0;
        end else if (i_bus_valid) begin
            tmr_owner <= tmr_hit;
        end
    end

    // only one target can answer at a time
    assign o_bus_done = i_tmr_done | i_ram_done;
    assign o_bus_rsp  = tmr_owner ? i_tmr_rsp : i_ram_rsp;

endmodule

// ==== design/clint_timer.sv ====
// Core-local timer
`timescale 1ns/1ps

module clint_timer (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_valid,
    input  soc_pkg::bus_req_t  i_req,
    output logic               o_done,
    output soc_pkg::bus_rsp_t  o_rsp,
    output logic               o_irq
);
    import soc_pkg::*;

    data_t mtime;
    data_t mtimecmp;
    data_t rdata_q;
    logic  done_q;
    logic  irq_q;
    logic  wr_mtime;
    logic  wr_mtimecmp;

    // overwrite only the bytes enabled in the mask
    function automatic data_t merge_bytes(data_t old_val, data_t new_val, wmask_t mask);
        data_t result;
        result = old_val;
        for (int i = 0; i < WMASK_W; i++) begin
            if (mask[i]) begin
                result[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return result;
    endfunction

    assign wr_mtime    = i_valid && i_req.we && (i_req.addr == MTIME_ADDR);
    assign wr_mtimecmp = i_valid && i_req.we && (i_req.addr == MTIMECMP_ADDR);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            mtime    <= MTIME_RESET;
            mtimecmp <= MTIMECMP_RESET;
            done_q   <= 1'b0;
            irq_q    <= 1'b0;
        end else begin
            // a write to mtime replaces this cycle's increment
            if (wr_mtime) begin
                mtime <= merge_bytes(mtime, i_req.wdata, i_req.wmask);
            end else begin
                mtime <= mtime + 1'b1;
            end
            if (wr_mtimecmp) begin
                mtimecmp <= merge_bytes(mtimecmp, i_req.wdata, i_req.wmask);
            end
            done_q <= i_valid;
            irq_q  <= (mtime >= mtimecmp);
        end
    end

    // read data, unmapped offsets read as zero
    always_ff @(posedge clk) begin
        if (i_valid) begin
            if (!i_req.we && i_req.addr == MTIME_ADDR) begin
                rdata_q <= mtime;
            end else if (!i_req.we && i_req.addr == MTIMECMP_ADDR) begin
                rdata_q <= mtimecmp;
            end else begin
                rdata_q <= '0;
            end
        end
    end

    assign o_done      = done_q;
    assign o_rsp.rdata = rdata_q;
    assign o_irq       = irq_q;

endmodule

// ==== design/ram_bridge.sv ====
// Bus to external RAM bridge
`timescale 1ns/1ps

module ram_bridge (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_valid,
    input  soc_pkg::bus_req_t  i_req,
    output logic               o_done,
    output soc_pkg::bus_rsp_t  o_rsp,
    // external ram strobes
    output logic               o_ram_rd_en,
    output soc_pkg::addr_t     o_ram_addr,
    input  soc_pkg::data_t     i_ram_rd_data,
    output logic               o_ram_wr_en,
    output soc_pkg::addr_t     o_ram_wr_addr,
    output soc_pkg::data_t     o_ram_wr_data,
    output soc_pkg::wmask_t    o_ram_wmask
);
    import soc_pkg::*;

    bridge_state_t state;
    logic          rd_en_q;
    logic          wr_en_q;
    logic          done_q;
    addr_t         rd_addr_q;
    addr_t         wr_addr_q;
    data_t         wr_data_q;
    wmask_t        wmask_q;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state   <= BR_IDLE;
            rd_en_q <= 1'b0;
            wr_en_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            case (state)
                BR_IDLE: begin
                    if (i_valid && i_req.we) begin
                        // write completes with its strobe
                        state   <= BR_WRITE;
                        wr_en_q <= 1'b1;
                        done_q  <= 1'b1;
                    end else if (i_valid) begin
                        state   <= BR_READ;
                        rd_en_q <= 1'b1;
                    end
                end
                BR_READ: begin
                    // data comes back one cycle after the strobe
                    state   <= BR_CAPTURE;
                    rd_en_q <= 1'b0;
                    done_q  <= 1'b1;
                end
                BR_CAPTURE, BR_WRITE: begin
                    state   <= BR_IDLE;
                    wr_en_q <= 1'b0;
                    done_q  <= 1'b0;
                end
                default: state <= BR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == BR_IDLE && i_valid && i_req.we) begin
            wr_addr_q <= i_req.addr;
            wr_data_q <= i_req.wdata;
            wmask_q   <= i_req.wmask;
        end
        if (state == BR_IDLE && i_valid && !i_req.we) begin
            rd_addr_q <= i_req.addr;
        end
    end

    assign o_ram_rd_en   = rd_en_q;
    assign o_ram_addr    = rd_addr_q;
    assign o_ram_wr_en   = wr_en_q;
    assign o_ram_wr_addr = wr_addr_q;
    assign o_ram_wr_data = wr_data_q;
    assign o_ram_wmask   = wmask_q;
    assign o_done        = done_q;

    // ram data is taken in the capture cycle, together with done
    assign o_rsp.rdata = (state == BR_CAPTURE) ? i_ram_rd_data : '0;

endmodule

// ==== design/soc_top.sv ====
// SoC memory subsystem top
`timescale 1ns/1ps

module soc_top (
    input  logic               clk,
    input  logic               i_rst_n,
    // instruction fetch
    input  logic               i_if_req,
    input  soc_pkg::addr_t     i_if_addr,
    output logic               o_if_done,
    output soc_pkg::inst_t     o_if_inst,
    // data access
    input  logic               i_mem_req,
    input  logic               i_mem_we,
    input  soc_pkg::addr_t     i_mem_addr,
    input  soc_pkg::data_t     i_mem_wdata,
    input  soc_pkg::wmask_t    i_mem_wmask,
    output logic               o_mem_done,
    output soc_pkg::data_t     o_mem_rdata,
    output logic               o_timer_irq,
    // external ram
    output logic               o_ram_rd_en,
    output soc_pkg::addr_t     o_ram_addr,
    input  soc_pkg::data_t     i_ram_rd_data,
    output logic               o_ram_wr_en,
    output soc_pkg::addr_t     o_ram_wr_addr,
    output soc_pkg::data_t     o_ram_wr_data,
    output soc_pkg::wmask_t    o_ram_wmask
);
    import soc_pkg::*;

    logic     bus_valid;
    bus_req_t bus_req;
    logic     bus_done;
    bus_rsp_t bus_rsp;
    logic     tmr_valid;
    logic     tmr_done;
    bus_rsp_t tmr_rsp;
    logic     ram_valid;
    logic     ram_done;
    bus_rsp_t ram_rsp;

    mem_arbiter u_arbiter (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_if_req    (i_if_req),
        .i_if_addr   (i_if_addr),
        .o_if_done   (o_if_done),
        .o_if_inst   (o_if_inst),
        .i_mem_req   (i_mem_req),
        .i_mem_we    (i_mem_we),
        .i_mem_addr  (i_mem_addr),
        .i_mem_wdata (i_mem_wdata),
        .i_mem_wmask (i_mem_wmask),
        .o_mem_done  (o_mem_done),
        .o_mem_rdata (o_mem_rdata),
        .o_bus_valid (bus_valid),
        .o_bus_req   (bus_req),
        .i_bus_done  (bus_done),
        .i_bus_rsp   (bus_rsp)
    );

    bus_router u_router (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_bus_valid (bus_valid),
        .i_bus_req   (bus_req),
        .o_bus_done  (bus_done),
        .o_bus_rsp   (bus_rsp),
        .o_tmr_valid (tmr_valid),
        .o_ram_valid (ram_valid),
        .i_tmr_done  (tmr_done),
        .i_tmr_rsp   (tmr_rsp),
        .i_ram_done  (ram_done),
        .i_ram_rsp   (ram_rsp)
    );

    // both targets see the same request, only their valids differ
    clint_timer u_timer (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_valid (tmr_valid),
        .i_req   (bus_req),
        .o_done  (tmr_done),
        .o_rsp   (tmr_rsp),
        .o_irq   (o_timer_irq)
    );

    ram_bridge u_ram_bridge (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_valid       (ram_valid),
        .i_req         (bus_req),
        .o_done        (ram_done),
        .o_rsp         (ram_rsp),
        .o_ram_rd_en   (o_ram_rd_en),
        .o_ram_addr    (o_ram_addr),
        .i_ram_rd_data (i_ram_rd_data),
        .o_ram_wr_en   (o_ram_wr_en),
        .o_ram_wr_addr (o_ram_wr_addr),
        .o_ram_wr_data (o_ram_wr_data),
        .o_ram_wmask   (o_ram_wmask)
    );

endmodule

// ==== tb/tb_ram_model.sv ====
// Behavioural external RAM
`timescale 1ns/1ps

module tb_ram_model (
    input  logic            clk,
    input  logic            i_rd_en,
    input  soc_pkg::addr_t  i_rd_addr,
    output soc_pkg::data_t  o_rd_data,
    input  logic            i_wr_en,
    input  soc_pkg::addr_t  i_wr_addr,
    input  soc_pkg::data_t  i_wr_data,
    input  soc_pkg::wmask_t i_wmask
);
    import soc_pkg::*;

    // sparse storage, one entry per 8-byte word
    data_t mem [addr_t];

    // words never written return a pattern of their own address
    function automatic data_t word_at(addr_t word_addr);
        if (mem.exists(word_addr)) begin
            return mem[word_addr];
        end
        return {word_addr[60:0], 3'b000} ^ 64'h5a5a_c3c3_0f0f_9696;
    endfunction

    initial begin
        o_rd_data = '0;
    end

    always @(posedge clk) begin
        data_t word;
        if (i_wr_en) begin
            word = word_at(i_wr_addr >> 3);
            for (int b = 0; b < WMASK_W; b++) begin
                if (i_wmask[b]) begin
                    word[8*b +: 8] = i_wr_data[8*b +: 8];
                end
            end
            mem[i_wr_addr >> 3] = word;
        end
        // data is back one cycle after the strobe
        if (i_rd_en) begin
            o_rd_data <= word_at(i_rd_addr >> 3);
        end
    end

endmodule

// ==== tb/tb_soc_top.sv ====
// SoC memory subsystem testbench
`timescale 1ns/1ps

module tb_soc_top;
    import soc_pkg::*;

    localparam int N_WORDS  = 16;
    localparam int N_WRITES = 40;
    localparam int N_READS  = 40;
    localparam int N_FETCH  = 24;
    localparam int N_DUAL   = 8;
    localparam int N_UNUSED = 8;
    // timer section issues seven accesses, each dual test two
    localparam int NUM_OPS  = N_WORDS + N_WRITES + N_READS + N_FETCH
                            + 2 * N_DUAL + N_UNUSED + 7;

    logic   clk;
    logic   rst_n;
    logic   if_req;
    addr_t  if_addr;
    logic   if_done;
    inst_t  if_inst;
    logic   mem_req;
    logic   mem_we;
    addr_t  mem_addr;
    data_t  mem_wdata;
    wmask_t mem_wmask;
    logic   mem_done;
    data_t  mem_rdata;
    logic   timer_irq;
    logic   ram_rd_en;
    addr_t  ram_addr;
    data_t  ram_rd_data;
    logic   ram_wr_en;
    addr_t  ram_wr_addr;
    data_t  ram_wr_data;
    wmask_t ram_wmask;

    // reference state
    data_t  ref_mem [addr_t];
    addr_t  pool [N_WORDS];
    data_t  cmp_model;
    int     rd_strobes;

    soc_top UUT (
        .clk(clk), .i_rst_n(rst_n),
        .i_if_req(if_req), .i_if_addr(if_addr), .o_if_done(if_done), .o_if_inst(if_inst),
        .i_mem_req(mem_req), .i_mem_we(mem_we), .i_mem_addr(mem_addr),
        .i_mem_wdata(mem_wdata), .i_mem_wmask(mem_wmask),
        .o_mem_done(mem_done), .o_mem_rdata(mem_rdata), .o_timer_irq(timer_irq),
        .o_ram_rd_en(ram_rd_en), .o_ram_addr(ram_addr), .i_ram_rd_data(ram_rd_data),
        .o_ram_wr_en(ram_wr_en), .o_ram_wr_addr(ram_wr_addr),
        .o_ram_wr_data(ram_wr_data), .o_ram_wmask(ram_wmask)
    );

    tb_ram_model u_ram (
        .clk(clk), .i_rd_en(ram_rd_en), .i_rd_addr(ram_addr), .o_rd_data(ram_rd_data),
        .i_wr_en(ram_wr_en), .i_wr_addr(ram_wr_addr), .i_wr_data(ram_wr_data),
        .i_wmask(ram_wmask)
    );

    always #2 clk = ~clk;

    // external read strobes, watched during timer window reads
    always @(posedge clk) begin
        if (ram_rd_en) begin
            rd_strobes <= rd_strobes + 1;
        end
    end

    initial begin
        repeat (NUM_OPS * 20 + 200) @(posedge clk);
        abort_run("watchdog expired before all tests finished");
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("mismatch at %0t ns: %s", $time, msg));
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_inst(input inst_t got, input inst_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_irq(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    // byte lanes enabled in the mask take the new value
    function automatic data_t apply_mask(data_t old_val, data_t new_val, wmask_t mask);
        data_t lanes;
        for (int b = 0; b < 8; b++) begin
            lanes[8*b +: 8] = {8{mask[b]}};
        end
        return (old_val & ~lanes) | (new_val & lanes);
    endfunction

    function automatic inst_t expected_inst(addr_t addr);
        data_t word;
        word = ref_mem[{addr[63:3], 3'b000}];
        return addr[2] ? word[63:32] : word[31:0];
    endfunction

    // called on a falling edge, returns on the falling edge of the done cycle
    task automatic data_access(input logic we, input addr_t addr, input data_t wdata,
                               input wmask_t mask, output data_t rdata);
        int n;
        mem_req   = 1'b1;
        mem_we    = we;
        mem_addr  = addr;
        mem_wdata = wdata;
        mem_wmask = mask;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!mem_done && n < 20);
        if (!mem_done) begin
            abort_run($sformatf("no data done within 20 cycles for address %h", addr));
        end else begin
            rdata   = mem_rdata;
            mem_req = 1'b0;
        end
    endtask

    task automatic write_word(input addr_t addr, input data_t wdata, input wmask_t mask);
        data_t ignored;
        data_access(1'b1, addr, wdata, mask, ignored);
    endtask

    task automatic read_word(input addr_t addr, output data_t rdata);
        data_access(1'b0, addr, '0, '0, rdata);
    endtask

    task automatic fetch(input addr_t addr, output inst_t inst);
        int n;
        if_req  = 1'b1;
        if_addr = addr;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!if_done && n < 20);
        if (!if_done) begin
            abort_run($sformatf("no fetch done within 20 cycles for address %h", addr));
        end else begin
            inst   = if_inst;
            if_req = 1'b0;
        end
    endtask

    // both levels rise together, data must be served first
    task automatic dual_request(input addr_t d_addr, input addr_t f_addr);
        arb_state_t next_owner;
        int         n;
        bit         d_seen;
        bit         f_seen;
        next_owner = ARB_DATA;
        d_seen     = 1'b0;
        f_seen     = 1'b0;
        mem_req    = 1'b1;
        mem_we     = 1'b0;
        mem_addr   = d_addr;
        mem_wmask  = '0;
        if_req     = 1'b1;
        if_addr    = f_addr;
        n = 0;
        while (!(d_seen && f_seen) && n < 40) begin
            @(negedge clk);
            n++;
            // fetch done is only legal after an earlier data done
            if (if_done) begin
                if (next_owner != ARB_INST) begin
                    report_mismatch("instruction done arrived before data done");
                end
                check_inst(if_inst, expected_inst(f_addr), "dual fetch");
                if_req = 1'b0;
                f_seen = 1'b1;
            end
            if (mem_done) begin
                if (next_owner != ARB_DATA) begin
                    report_mismatch("data done arrived out of order");
                end
                check_data(mem_rdata, ref_mem[d_addr], "dual data read");
                mem_req    = 1'b0;
                d_seen     = 1'b1;
                next_owner = ARB_INST;
            end
        end
        if (!(d_seen && f_seen)) begin
            abort_run("dual request did not complete within 40 cycles");
        end
    endtask

    task automatic wait_irq(input logic level, input string what);
        int n;
        n = 0;
        while (timer_irq !== level && n < 5) begin
            @(negedge clk);
            n++;
        end
        check_irq(timer_irq, level, what);
    endtask

    initial begin
        addr_t  addr;
        data_t  wdata;
        data_t  rdata;
        data_t  t0;
        data_t  t1;
        wmask_t mask;
        inst_t  inst;
        int     idx;
        int     strobes_before;
        void'($urandom(8));
        clk        = 1'b0;
        rst_n      = 1'b0;
        if_req     = 1'b0;
        if_addr    = '0;
        mem_req    = 1'b0;
        mem_we     = 1'b0;
        mem_addr   = '0;
        mem_wdata  = '0;
        mem_wmask  = '0;
        rd_strobes = 0;
        cmp_model  = '1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_irq(timer_irq, 1'b0, "irq after reset");

        // fill a pool of RAM words, bit 31 keeps them out of the timer window
        for (int k = 0; k < N_WORDS; k++) begin
            addr      = {$urandom(), $urandom()};
            addr[31]  = 1'b1;
            addr[2:0] = 3'b000;
            pool[k]   = addr;
            wdata     = {$urandom(), $urandom()};
            write_word(addr, wdata, 8'hff);
            ref_mem[addr] = wdata;
        end
        for (int k = 0; k < N_WRITES; k++) begin
            idx   = $urandom_range(0, N_WORDS - 1);
            wdata = {$urandom(), $urandom()};
            mask  = $urandom_range(0, 255);
            write_word(pool[idx], wdata, mask);
            ref_mem[pool[idx]] = apply_mask(ref_mem[pool[idx]], wdata, mask);
        end
        for (int k = 0; k < N_READS; k++) begin
            idx = $urandom_range(0, N_WORDS - 1);
            read_word(pool[idx], rdata);
            check_data(rdata, ref_mem[pool[idx]], "ram read");
        end

        for (int k = 0; k < N_FETCH; k++) begin
            addr    = pool[$urandom_range(0, N_WORDS - 1)];
            addr[2] = $urandom_range(0, 1);
            fetch(addr, inst);
            check_inst(inst, expected_inst(addr), "fetch");
        end
        for (int k = 0; k < N_DUAL; k++) begin
            addr    = pool[$urandom_range(0, N_WORDS - 1)];
            addr[2] = $urandom_range(0, 1);
            dual_request(pool[$urandom_range(0, N_WORDS - 1)], addr);
        end

        // masked compare write, then mtime must keep counting
        wdata     = {$urandom(), $urandom()};
        mask      = $urandom_range(1, 255);
        cmp_model = apply_mask(cmp_model, wdata, mask);
        write_word(MTIMECMP_ADDR, wdata, mask);
        read_word(MTIMECMP_ADDR, rdata);
        check_data(rdata, cmp_model, "mtimecmp readback");
        read_word(MTIME_ADDR, t0);
        read_word(MTIME_ADDR, t1);
        if (t1 <= t0) begin
            report_mismatch($sformatf("mtime went from %h to %h", t0, t1));
        end

        cmp_model = '0;
        write_word(MTIMECMP_ADDR, cmp_model, 8'hff);
        wait_irq(1'b1, "irq after mtimecmp cleared");
        cmp_model = '1;
        write_word(MTIMECMP_ADDR, cmp_model, 8'hff);
        wait_irq(1'b0, "irq after mtimecmp set");
        read_word(MTIMECMP_ADDR, rdata);
        check_data(rdata, cmp_model, "mtimecmp all ones");

        // unmapped timer offsets read zero and stay off the RAM port
        for (int k = 0; k < N_UNUSED; k++) begin
            addr = CLINT_BASE | addr_t'({$urandom_range(0, 8191), 3'b000});
            if (addr == MTIME_ADDR || addr == MTIMECMP_ADDR) begin
                addr = addr ^ 64'h8;
            end
            strobes_before = rd_strobes;
            read_word(addr, rdata);
            check_data(rdata, '0, "unused timer offset");
            if (rd_strobes != strobes_before) begin
                report_mismatch($sformatf("ram read strobe for timer address %h", addr));
            end
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== files.f ====
design/soc_pkg.sv
design/mem_arbiter.sv
design/bus_router.sv
design/clint_timer.sv
design/ram_bridge.sv
design/soc_top.sv
tb/tb_ram_model.sv
tb/tb_soc_top.sv
